// ==== rtl/exec_pkg.sv ====
// Execute slice shared definitions
// Data widths, operand and operation encodings, CSR addresses
// and memory stage latency
`default_nettype none

package exec_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  localparam int REG_NUM = 2 ** REG_AW;
  localparam int CSR_AW  = 12;

  // Operand source
  typedef enum logic [1:0] {
    REG_RF = 2'd0,
    IMM    = 2'd1,
    ZERO   = 2'd2,
    PC     = 2'd3
  } op_sel_t;

  // RV32I ALU funct3
  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } alu_f3_t;

  // Branch funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Word-only memory operations
  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_t;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_t;

  localparam logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_AW-1:0] CSR_MTVEC    = 12'h305;

  // Data memory, word addressed
  localparam int DMEM_WORDS = 16;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // Extra cycles a load occupies the memory stage
  localparam int LOAD_LAT = 2;
  localparam int LAT_W    = $clog2(LOAD_LAT + 1);

endpackage

`default_nettype wire

// ==== rtl/regfile.sv ====
// Integer register file
// 32 x 32 bits, two combinational read ports, one write port,
// x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module regfile
  import exec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n_i,
  input  wire [REG_AW-1:0]   rs1_addr_i,
  input  wire [REG_AW-1:0]   rs2_addr_i,
  output logic [XLEN-1:0]    rs1_data_o,
  output logic [XLEN-1:0]    rs2_data_o,
  input  wire                we_i,
  input  wire [REG_AW-1:0]   rd_addr_i,
  input  wire [XLEN-1:0]     rd_data_i
);

  logic [XLEN-1:0] regs_q [REG_NUM];

  always_ff @(posedge clk or negedge arst_n_i) begin : rf_write
    if (!arst_n_i) begin
      for (int i = 0; i < REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // No write bypass, execute forwards the writeback value
  always_comb begin : rf_read
    rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];
  end

endmodule

`default_nettype wire

// ==== rtl/csr.sv ====
// Machine CSRs for the execute stage
// mscratch and mtvec with read-write, set and clear access,
// old value returned on the read port
`timescale 1ns/1ps
`default_nettype none

module csr
  import exec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n_i,
  input  wire                stall_i,
  input  wire                kill_i,
  input  wire csr_op_t       op_i,
  input  wire [CSR_AW-1:0]   addr_i,
  input  wire [XLEN-1:0]     wdata_i,
  output logic [XLEN-1:0]    rdata_o
);

  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] new_val;
  logic            csr_wr;

  always_comb begin : csr_read
    case (addr_i)
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      default:      rdata_o = '0;
    endcase
  end

  always_comb begin : csr_modify
    case (op_i)
      CSR_RW:  new_val = wdata_i;
      CSR_RS:  new_val = rdata_o | wdata_i;
      CSR_RC:  new_val = rdata_o & ~wdata_i;
      default: new_val = rdata_o;
    endcase
  end

  // Squashed or stalled operations leave the CSRs untouched
  assign csr_wr = (op_i != CSR_NONE) && !stall_i && !kill_i;

  always_ff @(posedge clk or negedge arst_n_i) begin : csr_update
    if (!arst_n_i) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
    end else if (csr_wr) begin
      if (addr_i == CSR_MSCRATCH) begin
        mscratch_q <= new_val;
      end
      if (addr_i == CSR_MTVEC) begin
        mtvec_q <= new_val;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
// Execute stage
// Operand select and forwarding, ALU, branch and jump resolution,
// CSR access, redirect pulse and the EX/MEM pipeline register
`timescale 1ns/1ps
`default_nettype none

module execute
  import exec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n_i,
  // Decode port
  input  wire                id_valid_i,
  output logic               id_ready_o,
  input  wire op_sel_t       rs1_sel_i,
  input  wire op_sel_t       rs2_sel_i,
  input  wire [REG_AW-1:0]   rs1_addr_i,
  input  wire [REG_AW-1:0]   rs2_addr_i,
  input  wire [REG_AW-1:0]   rd_addr_i,
  input  wire                we_rd_i,
  input  wire [XLEN-1:0]     imm_i,
  input  wire [XLEN-1:0]     pc_i,
  input  wire [2:0]          f3_i,
  input  wire                sub_sra_i,
  input  wire                branch_i,
  input  wire                jump_i,
  input  wire lsu_op_t       lsu_op_i,
  input  wire csr_op_t       csr_op_i,
  input  wire [CSR_AW-1:0]   csr_addr_i,
  // Register file read data
  input  wire [XLEN-1:0]     rs1_data_i,
  input  wire [XLEN-1:0]     rs2_data_i,
  // From memory/writeback
  input  wire [XLEN-1:0]     wb_value_i,
  input  wire                lsu_bp_i,
  // EX/MEM register
  output logic               mem_valid_o,
  output logic [XLEN-1:0]    mem_result_o,
  output logic [REG_AW-1:0]  mem_rd_o,
  output logic               mem_we_o,
  output lsu_op_t            mem_lsu_op_o,
  output logic [XLEN-1:0]    mem_wdata_o,
  // Redirect
  output logic               fetch_req_o,
  output logic [XLEN-1:0]    fetch_addr_o
);

  logic                   accept;
  logic                   fwd_ok;
  logic [XLEN-1:0]        rs1_val;
  logic [XLEN-1:0]        rs2_val;
  logic [XLEN-1:0]        op1;
  logic [XLEN-1:0]        op2;
  logic signed [XLEN-1:0] sra_res;
  logic [XLEN-1:0]        alu_res;
  logic [XLEN-1:0]        ex_result;
  logic [XLEN-1:0]        target;
  logic [XLEN-1:0]        csr_rdata;
  csr_op_t                csr_op;
  logic                   taken;
  logic                   squash_q;

  function automatic logic branch_dec(branch_t cond, logic [XLEN-1:0] a,
                                      logic [XLEN-1:0] b);
    case (cond)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] operand(op_sel_t sel, logic [XLEN-1:0] rf_val,
                                              logic [XLEN-1:0] imm, logic [XLEN-1:0] pc);
    case (sel)
      REG_RF:  return rf_val;
      IMM:     return imm;
      PC:      return pc;
      default: return '0;
    endcase
  endfunction

  assign id_ready_o = !lsu_bp_i;
  assign accept     = id_valid_i && id_ready_o;

  // Forward the writeback value over a stale register file read
  assign fwd_ok  = mem_we_o && (mem_rd_o != '0);
  assign rs1_val = (fwd_ok && (mem_rd_o == rs1_addr_i)) ? wb_value_i : rs1_data_i;
  assign rs2_val = (fwd_ok && (mem_rd_o == rs2_addr_i)) ? wb_value_i : rs2_data_i;

  assign op1     = operand(rs1_sel_i, rs1_val, imm_i, pc_i);
  assign op2     = operand(rs2_sel_i, rs2_val, imm_i, pc_i);
  assign sra_res = $signed(op1) >>> op2[4:0];

  always_comb begin : alu
    case (alu_f3_t'(f3_i))
      ADD_SUB: alu_res = sub_sra_i ? op1 - op2 : op1 + op2;
      SLL:     alu_res = op1 << op2[4:0];
      SLT:     alu_res = ($signed(op1) < $signed(op2)) ? XLEN'(1) : '0;
      SLTU:    alu_res = (op1 < op2) ? XLEN'(1) : '0;
      XOR:     alu_res = op1 ^ op2;
      SRL_SRA: alu_res = sub_sra_i ? sra_res : op1 >> op2[4:0];
      OR:      alu_res = op1 | op2;
      AND:     alu_res = op1 & op2;
      default: alu_res = '0;
    endcase
  end

  assign taken  = jump_i || (branch_i && branch_dec(branch_t'(f3_i), rs1_val, rs2_val));
  assign target = jump_i ? {alu_res[XLEN-1:1], 1'b0} : pc_i + imm_i;

  always_comb begin : result_sel
    if (jump_i) begin
      ex_result = pc_i + XLEN'(4);
    end else if (csr_op_i != CSR_NONE) begin
      ex_result = csr_rdata;
    end else begin
      ex_result = alu_res;
    end
  end

  assign csr_op = id_valid_i ? csr_op_i : CSR_NONE;

  csr u_csr (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stall_i  (lsu_bp_i),
    .kill_i   (squash_q),
    .op_i     (csr_op),
    .addr_i   (csr_addr_i),
    .wdata_i  (op1),
    .rdata_o  (csr_rdata)
  );

  // squash_q marks the next accepted operation as dead
  always_ff @(posedge clk or negedge arst_n_i) begin : ctrl_regs
    if (!arst_n_i) begin
      mem_valid_o  <= 1'b0;
      mem_we_o     <= 1'b0;
      mem_lsu_op_o <= LSU_NONE;
      fetch_req_o  <= 1'b0;
      squash_q     <= 1'b0;
    end else begin
      fetch_req_o <= accept && taken && !squash_q;
      if (accept) begin
        squash_q <= taken && !squash_q;
      end
      if (!lsu_bp_i) begin
        mem_valid_o  <= id_valid_i;
        mem_we_o     <= id_valid_i && we_rd_i && !squash_q;
        mem_lsu_op_o <= (id_valid_i && !squash_q) ? lsu_op_i : LSU_NONE;
      end
    end
  end

  always_ff @(posedge clk) begin : payload_regs
    if (!lsu_bp_i) begin
      mem_result_o <= ex_result;
      mem_rd_o     <= rd_addr_i;
      mem_wdata_o  <= rs2_val;
    end
    if (accept && (branch_i || jump_i)) begin
      fetch_addr_o <= target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lsu_wb.sv ====
// Memory and writeback stage
// 16-word data memory, loads held for a fixed latency with
// back-pressure to execute, drives the register write port
`timescale 1ns/1ps
`default_nettype none

module lsu_wb
  import exec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n_i,
  input  wire                mem_valid_i,
  input  wire [XLEN-1:0]     mem_result_i,
  input  wire [REG_AW-1:0]   mem_rd_i,
  input  wire                mem_we_i,
  input  wire lsu_op_t       mem_lsu_op_i,
  input  wire [XLEN-1:0]     mem_wdata_i,
  output logic               lsu_bp_o,
  output logic               wb_we_o,
  output logic [REG_AW-1:0]  wb_rd_o,
  output logic [XLEN-1:0]    wb_data_o
);

  logic [XLEN-1:0]    dmem_q [DMEM_WORDS];
  logic [DMEM_AW-1:0] dmem_addr;
  logic               is_load;
  logic               is_store;
  logic [LAT_W-1:0]   lat_cnt_q;

  // Word address from the ALU result
  assign dmem_addr = mem_result_i[DMEM_AW+1:2];
  assign is_load   = mem_valid_i && (mem_lsu_op_i == LSU_LOAD);
  assign is_store  = mem_valid_i && (mem_lsu_op_i == LSU_STORE);

  // Held high from the load's first cycle until the count expires
  assign lsu_bp_o = is_load && (lat_cnt_q < LOAD_LAT);

  always_ff @(posedge clk or negedge arst_n_i) begin : load_timer
    if (!arst_n_i) begin
      lat_cnt_q <= '0;
    end else if (lsu_bp_o) begin
      lat_cnt_q <= lat_cnt_q + 1'b1;
    end else begin
      lat_cnt_q <= '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin : dmem_write
    if (!arst_n_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem_q[i] <= '0;
      end
    end else if (is_store) begin
      dmem_q[dmem_addr] <= mem_wdata_i;
    end
  end

  always_comb begin : writeback
    wb_rd_o   = mem_rd_i;
    wb_data_o = is_load ? dmem_q[dmem_addr] : mem_result_i;
    // loads only write back once the latency has elapsed
    wb_we_o   = mem_valid_i && mem_we_i && (mem_rd_i != '0) && !is_store && !lsu_bp_o;
  end

endmodule

`default_nettype wire

// ==== rtl/exec_core.sv ====
// Execute slice top level
// Register file, execute stage and memory/writeback stage
`timescale 1ns/1ps
`default_nettype none

module exec_core
  import exec_pkg::*;
(
  input  wire                clk,
  input  wire                arst_n_i,
  // Decode port
  input  wire                id_valid_i,
  output logic               id_ready_o,
  input  wire op_sel_t       rs1_sel_i,
  input  wire op_sel_t       rs2_sel_i,
  input  wire [REG_AW-1:0]   rs1_addr_i,
  input  wire [REG_AW-1:0]   rs2_addr_i,
  input  wire [REG_AW-1:0]   rd_addr_i,
  input  wire                we_rd_i,
  input  wire [XLEN-1:0]     imm_i,
  input  wire [XLEN-1:0]     pc_i,
  input  wire [2:0]          f3_i,
  input  wire                sub_sra_i,
  input  wire                branch_i,
  input  wire                jump_i,
  input  wire lsu_op_t       lsu_op_i,
  input  wire csr_op_t       csr_op_i,
  input  wire [CSR_AW-1:0]   csr_addr_i,
  // Redirect
  output logic               fetch_req_o,
  output logic [XLEN-1:0]    fetch_addr_o,
  // Writeback
  output logic               wb_valid_o,
  output logic [REG_AW-1:0]  wb_rd_o,
  output logic [XLEN-1:0]    wb_data_o
);

  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  logic              lsu_bp;
  logic              mem_valid;
  logic [XLEN-1:0]   mem_result;
  logic [REG_AW-1:0] mem_rd;
  logic              mem_we;
  lsu_op_t           mem_lsu_op;
  logic [XLEN-1:0]   mem_wdata;

  regfile u_regfile (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_valid_o),
    .rd_addr_i  (wb_rd_o),
    .rd_data_i  (wb_data_o)
  );

  execute u_execute (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .id_valid_i   (id_valid_i),
    .id_ready_o   (id_ready_o),
    .rs1_sel_i    (rs1_sel_i),
    .rs2_sel_i    (rs2_sel_i),
    .rs1_addr_i   (rs1_addr_i),
    .rs2_addr_i   (rs2_addr_i),
    .rd_addr_i    (rd_addr_i),
    .we_rd_i      (we_rd_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .f3_i         (f3_i),
    .sub_sra_i    (sub_sra_i),
    .branch_i     (branch_i),
    .jump_i       (jump_i),
    .lsu_op_i     (lsu_op_i),
    .csr_op_i     (csr_op_i),
    .csr_addr_i   (csr_addr_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .wb_value_i   (wb_data_o),
    .lsu_bp_i     (lsu_bp),
    .mem_valid_o  (mem_valid),
    .mem_result_o (mem_result),
    .mem_rd_o     (mem_rd),
    .mem_we_o     (mem_we),
    .mem_lsu_op_o (mem_lsu_op),
    .mem_wdata_o  (mem_wdata),
    .fetch_req_o  (fetch_req_o),
    .fetch_addr_o (fetch_addr_o)
  );

  lsu_wb u_lsu_wb (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .mem_valid_i  (mem_valid),
    .mem_result_i (mem_result),
    .mem_rd_i     (mem_rd),
    .mem_we_i     (mem_we),
    .mem_lsu_op_i (mem_lsu_op),
    .mem_wdata_i  (mem_wdata),
    .lsu_bp_o     (lsu_bp),
    .wb_we_o      (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset source
// 4 ns clock, reset held low for the first three cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/exec_core_assert.sv ====
// Protocol checks for the execute slice top level
// Redirect pulse width, stall during loads, writeback to x0
`timescale 1ns/1ps
`default_nettype none

module exec_core_assert
  import exec_pkg::*;
(
  input wire              clk,
  input wire              arst_n_i,
  input wire              fetch_req_i,
  input wire              id_ready_i,
  input wire              mem_valid_i,
  input wire lsu_op_t     mem_lsu_op_i,
  input wire              wb_valid_i,
  input wire [REG_AW-1:0] wb_rd_i
);

  // Assertion failure count
  int fail_cnt;

  // Redirect is a single-cycle pulse
  redirect_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    fetch_req_i |=> !fetch_req_i)
    else begin
      fail_cnt++;
      $error("fetch_req_o was high for two cycles in a row");
    end

  // A load entering the memory stage holds off decode for LOAD_LAT cycles
  load_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    (mem_valid_i && (mem_lsu_op_i == LSU_LOAD) && $past(id_ready_i))
      |-> !id_ready_i [*LOAD_LAT] ##1 id_ready_i)
    else begin
      fail_cnt++;
      $error("id_ready_o was not low for exactly the load latency");
    end

  no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
    wb_valid_i |-> (wb_rd_i != '0))
    else begin
      fail_cnt++;
      $error("writeback to register x0");
    end

endmodule

bind exec_core exec_core_assert u_exec_core_assert (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .fetch_req_i  (fetch_req_o),
  .id_ready_i   (id_ready_o),
  .mem_valid_i  (mem_valid),
  .mem_lsu_op_i (mem_lsu_op),
  .wb_valid_i   (wb_valid_o),
  .wb_rd_i      (wb_rd_o)
);

`default_nettype wire

// ==== verif/exec_core_tb.sv ====
// Testbench for the execute slice
// Drives pre-decoded operations, predicts writebacks and redirects
// with an architectural model and compares them with the DUT
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
  import exec_pkg::*;
;

  typedef struct packed {
    op_sel_t     rs1_sel;
    op_sel_t     rs2_sel;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [2:0]  f3;
    logic        sub;
    logic        br;
    logic        jmp;
    lsu_op_t     lsu;
    csr_op_t     csr;
    logic [11:0] caddr;
  } op_t;

  // Upper bound on operations sent, sizes the watchdog
  localparam int MAX_OPS = 300;

  logic        clk;
  logic        arst_n;
  logic        id_valid;
  op_t         cur;
  logic        id_ready;
  logic        fetch_req;
  logic [31:0] fetch_addr;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  // Architectural model state
  logic [31:0] m_rf [32];
  logic [31:0] m_mem [16];
  logic [31:0] m_mscratch;
  logic [31:0] m_mtvec;
  bit          m_squash;

  logic [36:0] exp_wb_q [$];
  string       wb_name_q [$];
  logic [31:0] exp_redir_q [$];
  string       redir_name_q [$];
  int          wb_errs;
  int          redir_errs;
  int          assert_errs;
  int          other_errs;
  int          n_sent;

  tb_clk_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  exec_core exec_core_inst (
    .clk (clk), .arst_n_i (arst_n), .id_valid_i (id_valid), .id_ready_o (id_ready),
    .rs1_sel_i (cur.rs1_sel), .rs2_sel_i (cur.rs2_sel), .rs1_addr_i (cur.rs1),
    .rs2_addr_i (cur.rs2), .rd_addr_i (cur.rd), .we_rd_i (cur.we), .imm_i (cur.imm),
    .pc_i (cur.pc), .f3_i (cur.f3), .sub_sra_i (cur.sub), .branch_i (cur.br),
    .jump_i (cur.jmp), .lsu_op_i (cur.lsu), .csr_op_i (cur.csr), .csr_addr_i (cur.caddr),
    .fetch_req_o (fetch_req), .fetch_addr_o (fetch_addr),
    .wb_valid_o (wb_valid), .wb_rd_o (wb_rd), .wb_data_o (wb_data)
  );

  function automatic logic [31:0] ref_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0: return sub ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (sub) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit ref_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] pick(op_sel_t sel, logic [31:0] r, op_t op);
    case (sel)
      REG_RF: return r;
      IMM:    return op.imm;
      PC:     return op.pc;
      default: return 32'd0;
    endcase
  endfunction

  // One operation through the model: expected writeback and redirect
  function automatic void model(input op_t op, output bit wb_en, output logic [4:0] rd,
                                output logic [31:0] data, output bit redir,
                                output logic [31:0] redir_addr);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op1;
    logic [31:0] res;
    logic [31:0] old;
    bit          taken;
    a = m_rf[op.rs1];
    b = m_rf[op.rs2];
    op1 = pick(op.rs1_sel, a, op);
    res = ref_alu(op.f3, op.sub, op1, pick(op.rs2_sel, b, op));
    taken = op.jmp || (op.br && ref_cond(op.f3, a, b));
    wb_en = 0;
    rd = op.rd;
    data = '0;
    redir = 0;
    redir_addr = '0;
    if (m_squash) begin
      m_squash = 0;
      return;
    end
    m_squash = taken;
    redir = taken;
    redir_addr = op.jmp ? {res[31:1], 1'b0} : op.pc + op.imm;
    if (op.jmp) begin
      res = op.pc + 32'd4;
    end else if (op.csr != CSR_NONE) begin
      old = (op.caddr == CSR_MSCRATCH) ? m_mscratch :
            (op.caddr == CSR_MTVEC) ? m_mtvec : 32'd0;
      case (op.csr)
        CSR_RW:  op1 = op1;
        CSR_RS:  op1 = old | op1;
        default: op1 = old & ~op1;
      endcase
      if (op.caddr == CSR_MSCRATCH) m_mscratch = op1;
      if (op.caddr == CSR_MTVEC) m_mtvec = op1;
      res = old;
    end
    if (op.lsu == LSU_STORE) m_mem[res[5:2]] = b;
    data = (op.lsu == LSU_LOAD) ? m_mem[res[5:2]] : res;
    wb_en = op.we && (op.rd != 0) && (op.lsu != LSU_STORE);
    if (wb_en) m_rf[op.rd] = data;
  endfunction

  function automatic op_t alu_op(logic [2:0] f3, logic sub, logic [4:0] rd,
                                 logic [4:0] rs1, logic [4:0] rs2, bit use_imm,
                                 logic [31:0] imm);
    op_t op;
    op = '0;
    op.rs1_sel = REG_RF;
    op.rs2_sel = use_imm ? IMM : REG_RF;
    op.f3 = f3;
    op.sub = sub;
    op.rd = rd;
    op.rs1 = rs1;
    op.rs2 = rs2;
    op.imm = imm;
    op.we = 1'b1;
    op.pc = n_sent * 4;
    return op;
  endfunction

  function automatic op_t mem_op(lsu_op_t kind, logic [4:0] reg_a, logic [31:0] addr);
    op_t op;
    op = alu_op(3'd0, 0, reg_a, 5'd0, reg_a, 1, addr);
    op.lsu = kind;
    op.we = (kind == LSU_LOAD);
    return op;
  endfunction

  function automatic op_t ctl_op(bit jump, logic [2:0] f3, logic [4:0] rs1,
                                 logic [4:0] rs2, logic [4:0] rd, logic [31:0] imm);
    op_t op;
    op = alu_op(jump ? 3'd0 : f3, 0, rd, rs1, rs2, jump, imm);
    op.br = !jump;
    op.jmp = jump;
    op.we = jump;
    if (jump && rs1 == 0) op.rs1_sel = PC;
    return op;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(1 + $urandom % 31);
  endfunction

  task automatic send(input op_t op, input string name);
    logic        rdy;
    bit          wb_en;
    bit          redir;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] raddr;
    cur = op;
    id_valid = 1'b1;
    do begin
      @(negedge clk);
      rdy = id_ready;
      @(posedge clk);
    end while (!rdy);
    model(op, wb_en, rd, data, redir, raddr);
    if (wb_en) begin
      exp_wb_q.push_back({rd, data});
      wb_name_q.push_back(name);
    end
    if (redir) begin
      exp_redir_q.push_back(raddr);
      redir_name_q.push_back(name);
    end
    n_sent++;
    #1 id_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Comparator, outputs sampled mid-cycle
  initial begin : compare
    logic [36:0] exp;
    string       name;
    forever begin
      @(negedge clk);
      if (arst_n && wb_valid) begin
        if (exp_wb_q.size() == 0) begin
          other_errs++;
          $display("Unexpected writeback to x%0d with data %h", wb_rd, wb_data);
        end else begin
          exp = exp_wb_q.pop_front();
          name = wb_name_q.pop_front();
          assert ({wb_rd, wb_data} == exp) else begin
            wb_errs++;
            $display("** Error [%s] writeback expected x%0d=%h, actual x%0d=%h",
                     name, exp[36:32], exp[31:0], wb_rd, wb_data);
          end
        end
      end
      if (arst_n && fetch_req) begin
        if (exp_redir_q.size() == 0) begin
          other_errs++;
          $display("Unexpected redirect to %h", fetch_addr);
        end else begin
          name = redir_name_q.pop_front();
          exp[31:0] = exp_redir_q.pop_front();
          assert (fetch_addr == exp[31:0]) else begin
            redir_errs++;
            $display("** Error [%s] redirect expected %h, actual %h",
                     name, exp[31:0], fetch_addr);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (MAX_OPS * (LOAD_LAT + 3) + 100) @(posedge clk);
    $display("Watchdog expired before the stimulus completed");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] vals [3];
    logic [31:0] addr;
    logic [4:0]  ra;
    logic [4:0]  rb;
    int          kind;
    void'($urandom(32'h8a2cef76));
    id_valid = 1'b0;
    cur = '0;
    wb_errs = 0;
    redir_errs = 0;
    assert_errs = 0;
    other_errs = 0;
    n_sent = 0;
    m_squash = 0;
    m_mscratch = '0;
    m_mtvec = '0;
    foreach (m_rf[i]) m_rf[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    @(posedge arst_n);
    idle(2);
    for (int r = 1; r < 32; r++) send(alu_op(3'd0, 0, 5'(r), 0, 0, 1, $urandom), "init");
    // ALU coverage, both operand forms
    for (int i = 0; i < 40; i++) begin
      send(alu_op(3'(i % 8), ((i % 8 == 0) || (i % 8 == 5)) && (i % 16 >= 8),
                  rand_reg(), rand_reg(), rand_reg(), $urandom % 2, $urandom), "alu");
    end
    for (int i = 0; i < 4; i++) begin
      ra = rand_reg();
      rb = rand_reg();
      addr = ($urandom % 16) * 4;
      send(alu_op(3'd0, 0, 5'd12, ra, rb, 0, 0), "dep_rs1");
      send(alu_op(3'd4, 0, 5'd13, 5'd12, ra, 0, 0), "dep_rs1");
      send(alu_op(3'd0, 1, 5'd14, rb, 5'd13, 0, 0), "dep_rs2");
      send(mem_op(LSU_STORE, 5'd14, addr), "dep_store");
      send(mem_op(LSU_LOAD, 5'd15, addr), "dep_store");
      send(alu_op(3'd6, 0, 5'd16, 5'd15, 5'd15, 0, 0), "dep_load");
    end
    for (int i = 0; i < 12; i++) begin
      addr = ($urandom % 16) * 4;
      ra = rand_reg();
      send(mem_op(LSU_STORE, rand_reg(), addr), "ldst");
      send(mem_op(LSU_LOAD, ra, addr), "ldst");
      send(alu_op(3'd0, 0, rand_reg(), ra, rand_reg(), 0, 0), "ldst_use");
    end
    // Pairs give every condition both outcomes
    vals = '{32'd5, 32'hffff_fffe, 32'd7};
    foreach (vals[p]) begin
      for (int c = 0; c < 8; c++) begin
        if (c == 2 || c == 3) continue;
        send(alu_op(3'd0, 0, 5'd10, 0, 0, 1, vals[p]), "branch");
        send(alu_op(3'd0, 0, 5'd11, 0, 0, 1, p == 0 ? 32'd5 : vals[3 - p]), "branch");
        send(ctl_op(0, 3'(c), 5'd10, 5'd11, 0, 32'h40), "branch");
        send(alu_op(3'd0, 0, 5'd20, 5'd10, 5'd11, 0, 0), "branch_shadow");
      end
    end
    send(ctl_op(1, 0, 0, 0, 5'd21, 32'h100), "jal");
    send(ctl_op(1, 0, 0, 0, 5'd22, 32'h200), "jump_shadow");
    send(ctl_op(1, 0, 5'd10, 0, 5'd23, 32'h13), "jalr");
    send(mem_op(LSU_STORE, 5'd23, 32'h8), "jump_shadow");
    send(mem_op(LSU_LOAD, 5'd24, 32'h8), "jump_shadow");
    for (int i = 0; i < 2; i++) begin
      for (int k = 1; k < 4; k++) begin
        cur = alu_op(0, 0, rand_reg(), rand_reg(), 0, 0, 0);
        cur.csr = csr_op_t'(k);
        cur.caddr = i ? CSR_MTVEC : CSR_MSCRATCH;
        send(cur, "csr");
      end
      cur.csr = CSR_RS;
      cur.rs1 = 0;
      send(cur, "csr_read");
    end
    for (int i = 0; i < 50; i++) begin
      kind = $urandom % 6;
      addr = ($urandom % 16) * 4;
      case (kind)
        0: send(alu_op(3'($urandom), $urandom % 2, rand_reg(), rand_reg(), rand_reg(),
                       $urandom % 2, $urandom), "mix_alu");
        1: send(mem_op(LSU_LOAD, rand_reg(), addr), "mix_load");
        2: send(mem_op(LSU_STORE, rand_reg(), addr), "mix_store");
        3: send(ctl_op(0, 3'($urandom % 2), rand_reg(), rand_reg(), 0, addr), "mix_branch");
        4: send(ctl_op(1, 0, 0, 0, rand_reg(), addr), "mix_jump");
        default: begin
          cur = alu_op(0, 0, rand_reg(), rand_reg(), 0, 0, 0);
          cur.csr = csr_op_t'(1 + $urandom % 3);
          cur.caddr = ($urandom % 2) ? CSR_MTVEC : CSR_MSCRATCH;
          send(cur, "mix_csr");
        end
      endcase
      idle($urandom % 2);
    end
    idle(10);
    if (exp_wb_q.size() != 0 || exp_redir_q.size() != 0) begin
      other_errs += exp_wb_q.size() + exp_redir_q.size();
      $display("Missing results: %0d writebacks and %0d redirects never appeared",
               exp_wb_q.size(), exp_redir_q.size());
    end
    assert_errs = exec_core_inst.u_exec_core_assert.fail_cnt;
    $display("Sent %0d ops, errors: writeback %0d, redirect %0d, assertion %0d, other %0d",
             n_sent, wb_errs, redir_errs, assert_errs, other_errs);
    if (wb_errs + redir_errs + assert_errs + other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_core.f ====
rtl/exec_pkg.sv
rtl/regfile.sv
rtl/csr.sv
rtl/execute.sv
rtl/lsu_wb.sv
rtl/exec_core.sv
verif/tb_clk_gen.sv
verif/exec_core_assert.sv
verif/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/regfile.sv
      - rtl/csr.sv
      - rtl/execute.sv
      - rtl/lsu_wb.sv
      - rtl/exec_core.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/exec_core_assert.sv
      - verif/exec_core_tb.sv
